/* mio_geom_pkg.sv */
package mio_geom_pkg;

  // ############################
  // default FIFO geometry
  // ############################

  // the top level passes its own values down, these are only the defaults
  parameter int unsigned DEF_ADDR_W   = 7;   // 128 entries
  parameter int unsigned DEF_WR_LANES = 25;  // widest write burst in bytes
  parameter int unsigned DEF_RD_LANES = 4;   // bytes popped per read beat

  // ############################
  // width helpers
  // ############################

  // number of entries addressed by an addr_w bit pointer
  function automatic int unsigned depth_of(int unsigned addr_w);
    return 32'd1 << addr_w;
  endfunction

  // the occupancy count must also hold the full value, so one extra bit
  function automatic int unsigned cnt_w_of(int unsigned addr_w);
    return addr_w + 1;
  endfunction

endpackage

/* mio_types_pkg.sv */
package mio_types_pkg;

  // ############################
  // payload
  // ############################

  parameter int unsigned DATA_W = 8;  // width of one byte lane

  // one byte lane of the write or read port
  typedef logic [DATA_W-1:0] lane_t;

  // ############################
  // write lane count
  // ############################

  // holds 0 to 25, so it covers the default number of write lanes
  parameter int unsigned WR_COUNT_W = 5;

  // number of valid lanes on a write beat, packed from lane 0 upwards
  typedef logic [WR_COUNT_W-1:0] wr_count_t;

endpackage

/* mio_occupancy.sv */
`timescale 1ns/1ps

module mio_occupancy #(
  parameter int unsigned ADDR_W   = mio_geom_pkg::DEF_ADDR_W,
  parameter int unsigned WR_LANES = mio_geom_pkg::DEF_WR_LANES,
  parameter int unsigned RD_LANES = mio_geom_pkg::DEF_RD_LANES
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     wr_valid,
  input  mio_types_pkg::wr_count_t wr_count,
  output logic                     wr_ready,
  input  logic                     rd_ready,
  output logic                     rd_valid,
  output logic [ADDR_W-1:0]        wr_ptr,
  output logic [ADDR_W-1:0]        rd_ptr
);

  import mio_geom_pkg::*;

  localparam int unsigned DEPTH = depth_of(ADDR_W);
  localparam int unsigned CNT_W = cnt_w_of(ADDR_W);

  logic             wr_en;     // accepted write beat
  logic             rd_en;     // accepted pop
  logic [CNT_W-1:0] occ_q;     // bytes currently stored
  logic [CNT_W-1:0] wr_step;   // bytes added this cycle
  logic [CNT_W-1:0] rd_step;   // bytes removed this cycle

  // ############################
  // handshakes
  // ############################

  assign wr_en = wr_valid & wr_ready;
  assign rd_en = rd_valid & rd_ready;

  assign wr_step = wr_en ? CNT_W'(wr_count) : '0;
  assign rd_step = rd_en ? CNT_W'(RD_LANES) : '0;

  // ############################
  // pointers
  // ############################

  // the pointers wrap by simply overflowing the address width
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      wr_ptr <= '0;
    end
    else if (wr_en)
    begin
      wr_ptr <= wr_ptr + ADDR_W'(wr_count);  // only the stored lanes move it
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      rd_ptr <= '0;
    end
    else if (rd_en)
    begin
      rd_ptr <= rd_ptr + ADDR_W'(RD_LANES);  // a pop always takes the full group
    end
  end

  // ############################
  // occupancy
  // ############################

  // a write and a pop in the same cycle both take effect
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      occ_q <= '0;
    end
    else
    begin
      occ_q <= occ_q + wr_step - rd_step;
    end
  end

  // ready only while a full-width burst still fits, whatever wr_count is
  assign wr_ready = (int'(occ_q) + int'(WR_LANES)) <= int'(DEPTH);

  // valid only once a whole read group is stored
  assign rd_valid = int'(occ_q) >= int'(RD_LANES);

endmodule

/* mio_lane_store.sv */
`timescale 1ns/1ps

module mio_lane_store #(
  parameter int unsigned ADDR_W   = mio_geom_pkg::DEF_ADDR_W,
  parameter int unsigned WR_LANES = mio_geom_pkg::DEF_WR_LANES,
  parameter int unsigned RD_LANES = mio_geom_pkg::DEF_RD_LANES,
  parameter type         elem_t   = mio_types_pkg::lane_t
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     wr_en,
  input  mio_types_pkg::wr_count_t wr_count,
  input  elem_t [WR_LANES-1:0]     wr_data,
  input  logic [ADDR_W-1:0]        wr_ptr,
  input  logic [ADDR_W-1:0]        rd_ptr,
  input  logic                     rd_valid,
  output elem_t [RD_LANES-1:0]     rd_data
);

  import mio_geom_pkg::*;

  localparam int unsigned DEPTH = depth_of(ADDR_W);

  elem_t                mem [DEPTH];           // the FIFO entries
  logic  [ADDR_W-1:0]   wr_addr [WR_LANES];    // target entry of each write lane
  logic  [WR_LANES-1:0] wr_lane_en;            // lanes stored on this beat
  logic  [ADDR_W-1:0]   rd_addr [RD_LANES];    // source entry of each read lane

  // ############################
  // write side
  // ############################

  // lane i lands i entries past the write pointer, wrapping at the depth
  always_comb
  begin
    for (int i = 0; i < WR_LANES; i++)
    begin
      wr_addr[i]    = wr_ptr + ADDR_W'(i);
      wr_lane_en[i] = wr_en && (i < int'(wr_count));
    end
  end

  // enabled lanes never share an address, as long as the burst fits the depth
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      for (int k = 0; k < DEPTH; k++)
      begin
        mem[k] <= '0;
      end
    end
    else
    begin
      for (int i = 0; i < WR_LANES; i++)
      begin
        if (wr_lane_en[i])
        begin
          mem[wr_addr[i]] <= wr_data[i];
        end
      end
    end
  end

  // ############################
  // read side
  // ############################

  // lane 0 is the oldest byte, later lanes follow in write order
  always_comb
  begin
    for (int j = 0; j < RD_LANES; j++)
    begin
      rd_addr[j] = rd_ptr + ADDR_W'(j);
      rd_data[j] = rd_valid ? mem[rd_addr[j]] : '0;  // zero while nothing is offered
    end
  end

endmodule

/* mio_fifo_top.sv */
`timescale 1ns/1ps

module mio_fifo_top #(
  parameter int unsigned ADDR_W   = mio_geom_pkg::DEF_ADDR_W,
  parameter int unsigned WR_LANES = mio_geom_pkg::DEF_WR_LANES,
  parameter int unsigned RD_LANES = mio_geom_pkg::DEF_RD_LANES
) (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  // write port
  input  logic                                 wr_valid,
  output logic                                 wr_ready,
  input  mio_types_pkg::lane_t [WR_LANES-1:0]  wr_data,
  input  mio_types_pkg::wr_count_t             wr_count,
  // read port
  input  logic                                 rd_ready,
  output logic                                 rd_valid,
  output mio_types_pkg::lane_t [RD_LANES-1:0]  rd_data
);

  import mio_types_pkg::*;

  logic              wr_en;    // write strobe into the store
  logic [ADDR_W-1:0] wr_ptr;   // next free entry
  logic [ADDR_W-1:0] rd_ptr;   // oldest stored entry

  // a beat is only stored when the tracker also accepts it
  assign wr_en = wr_valid & wr_ready;

  // ############################
  // occupancy tracker
  // ############################

  mio_occupancy #(
    .ADDR_W   (ADDR_W),
    .WR_LANES (WR_LANES),
    .RD_LANES (RD_LANES)
  ) i_occupancy (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .wr_valid (wr_valid),
    .wr_count (wr_count),
    .wr_ready (wr_ready),
    .rd_ready (rd_ready),
    .rd_valid (rd_valid),
    .wr_ptr   (wr_ptr),
    .rd_ptr   (rd_ptr)
  );

  // ############################
  // byte storage
  // ############################

  mio_lane_store #(
    .ADDR_W   (ADDR_W),
    .WR_LANES (WR_LANES),
    .RD_LANES (RD_LANES),
    .elem_t   (lane_t)
  ) i_lane_store (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .wr_en    (wr_en),
    .wr_count (wr_count),
    .wr_data  (wr_data),
    .wr_ptr   (wr_ptr),
    .rd_ptr   (rd_ptr),
    .rd_valid (rd_valid),
    .rd_data  (rd_data)
  );

endmodule

/* mio_fifo_asserts.sv */
`timescale 1ns/1ps

module mio_fifo_asserts #(
  parameter int unsigned WR_LANES = mio_geom_pkg::DEF_WR_LANES,
  parameter int unsigned RD_LANES = mio_geom_pkg::DEF_RD_LANES
) (
  input logic                                clk_i,
  input logic                                rst_ni,
  input logic                                wr_valid,
  input logic                                wr_ready,
  input mio_types_pkg::wr_count_t            wr_count,
  input logic                                rd_ready,
  input logic                                rd_valid,
  input mio_types_pkg::lane_t [RD_LANES-1:0] rd_data
);

  logic bad_count = 1'b0;
  logic bad_zero  = 1'b0;
  logic bad_hold  = 1'b0;
  logic bad_reset = 1'b0;
  logic any_fail;  // sampled by the testbench

  assign any_fail = bad_count | bad_zero | bad_hold | bad_reset;

  // ##############################
  // port rules
  // ##############################

  count_in_range: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wr_valid |-> (int'(wr_count) <= int'(WR_LANES)))
    else
    begin
      $error("wr_count above the number of write lanes");
      bad_count = 1'b1;
    end

  zero_when_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !rd_valid |-> (rd_data == '0))
    else
    begin
      $error("rd_data not zero while rd_valid is low");
      bad_zero = 1'b1;
    end

  hold_on_stall: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (rd_valid && !rd_ready) |=> $stable(rd_data))
    else
    begin
      $error("rd_data changed while the read was stalled");
      bad_hold = 1'b1;
    end

  // the first edge after reset release sees an empty FIFO
  ready_after_reset: assert property (@(posedge clk_i)
    $rose(rst_ni) |-> wr_ready)
    else
    begin
      $error("wr_ready low in the first cycle after reset");
      bad_reset = 1'b1;
    end

endmodule

bind mio_fifo_top mio_fifo_asserts #(
  .WR_LANES (WR_LANES),
  .RD_LANES (RD_LANES)
) i_asserts (
  .clk_i    (clk_i),
  .rst_ni   (rst_ni),
  .wr_valid (wr_valid),
  .wr_ready (wr_ready),
  .wr_count (wr_count),
  .rd_ready (rd_ready),
  .rd_valid (rd_valid),
  .rd_data  (rd_data)
);

/* tb_mio_fifo.sv */
`timescale 1ns/1ps

module tb_mio_fifo;

  import mio_geom_pkg::*;
  import mio_types_pkg::*;

  localparam int unsigned WR_LANES = DEF_WR_LANES;
  localparam int unsigned RD_LANES = DEF_RD_LANES;
  localparam int unsigned DEPTH    = 128;
  localparam int          NUM_ROWS = 21;
  localparam int          TIMEOUT  = 200;  // cycles allowed for the final drain

  typedef logic [DEF_ADDR_W:0] occ_t;

  typedef struct packed {
    logic [2:0] grp;   // index into grp_name
    logic       wv;
    wr_count_t  cnt;
    logic       rr;
    logic       rnd;   // draw wr_valid, wr_count and rd_ready at random
    logic [7:0] reps;
  } row_t;

  logic                   clk_i;
  logic                   rst_ni;
  logic                   wr_valid;
  logic                   wr_ready;
  lane_t [WR_LANES-1:0]   wr_data;
  wr_count_t              wr_count;
  logic                   rd_ready;
  logic                   rd_valid;
  lane_t [RD_LANES-1:0]   rd_data;

  lane_t  model_q [$];           // bytes the FIFO should hold, oldest first
  lane_t  next_byte = '0;        // running write data counter
  integer seed      = 32'hbdbef81f;

  string grp_name [8] = '{"reset", "partial_fill", "burst_wrap", "fill_stall",
                          "drain", "simultaneous", "random_mix", "final_drain"};

  // ##############################
  // stimulus table
  // ##############################

  row_t rows [NUM_ROWS] = '{
    '{3'd1, 1'b1, 5'd1,  1'b0, 1'b0, 8'd1},    // one byte, rd_valid stays low
    '{3'd1, 1'b1, 5'd2,  1'b0, 1'b0, 8'd1},
    '{3'd1, 1'b1, 5'd1,  1'b0, 1'b0, 8'd1},    // fourth byte lands here
    '{3'd1, 1'b0, 5'd0,  1'b0, 1'b0, 8'd2},    // group of four offered and held
    '{3'd1, 1'b0, 5'd0,  1'b1, 1'b0, 8'd1},
    '{3'd2, 1'b1, 5'd25, 1'b1, 1'b0, 8'd12},
    '{3'd2, 1'b1, 5'd0,  1'b1, 1'b0, 8'd3},
    '{3'd2, 1'b1, 5'd13, 1'b1, 1'b0, 8'd20},
    '{3'd2, 1'b1, 5'd7,  1'b1, 1'b0, 8'd30},
    '{3'd2, 1'b1, 5'd25, 1'b1, 1'b0, 8'd20},
    '{3'd2, 1'b1, 5'd3,  1'b1, 1'b0, 8'd40},
    '{3'd4, 1'b0, 5'd0,  1'b1, 1'b0, 8'd40},   // nearly empty before the fill
    '{3'd3, 1'b1, 5'd25, 1'b0, 1'b0, 8'd8},    // five beats fit, the rest are refused
    '{3'd3, 1'b1, 5'd1,  1'b0, 1'b0, 8'd2},
    '{3'd4, 1'b0, 5'd0,  1'b1, 1'b0, 8'd40},
    '{3'd5, 1'b1, 5'd8,  1'b0, 1'b0, 8'd1},
    '{3'd5, 1'b1, 5'd4,  1'b1, 1'b0, 8'd10},   // level stays put
    '{3'd5, 1'b1, 5'd6,  1'b1, 1'b0, 8'd6},
    '{3'd5, 1'b1, 5'd1,  1'b1, 1'b0, 8'd5},
    '{3'd6, 1'b0, 5'd0,  1'b0, 1'b1, 8'd250},
    '{3'd6, 1'b0, 5'd0,  1'b0, 1'b1, 8'd250}
  };

  mio_fifo_top i_mio_fifo_top (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .wr_valid (wr_valid),
    .wr_ready (wr_ready),
    .wr_data  (wr_data),
    .wr_count (wr_count),
    .rd_ready (rd_ready),
    .rd_valid (rd_valid),
    .rd_data  (rd_data)
  );

  initial
  begin
    clk_i = 1'b0;
    forever
    begin
      #5 clk_i = ~clk_i;
    end
  end

  // ##############################
  // checks
  // ##############################

  task automatic abort_run();
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_level(input string name, input string what, input logic exp,
                             input logic act);
    if (act !== exp)
    begin
      $display("** Error %s: %s expected %0b, actual %0b", name, what, exp, act);
      abort_run();
    end
  endtask

  task automatic check_lanes(input string name, input lane_t [RD_LANES-1:0] exp,
                             input lane_t [RD_LANES-1:0] act);
    if (act !== exp)
    begin
      $display("** Error %s: rd_data expected %h, actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_occupancy(input string name, input occ_t exp, input occ_t act);
    if (act !== exp)
    begin
      $display("** Error %s: occupancy expected %0d, actual %0d", name, exp, act);
      abort_run();
    end
  endtask

  // outputs depend only on the stored state, so the model queue predicts them
  task automatic check_outputs(input string name);
    lane_t [RD_LANES-1:0] exp_data;
    logic                 exp_wr;
    logic                 exp_rv;
    exp_wr   = (model_q.size() + int'(WR_LANES)) <= int'(DEPTH);
    exp_rv   = model_q.size() >= int'(RD_LANES);
    exp_data = '0;
    for (int j = 0; j < int'(RD_LANES); j++)
    begin
      if (exp_rv)
      begin
        exp_data[j] = model_q[j];
      end
    end
    if (i_mio_fifo_top.i_asserts.any_fail)
    begin
      $display("a bound assertion on the FIFO ports failed during %s", name);
      abort_run();
    end
    check_level(name, "wr_ready", exp_wr, wr_ready);
    check_level(name, "rd_valid", exp_rv, rd_valid);
    check_lanes(name, exp_data, rd_data);
    check_occupancy(name, occ_t'(model_q.size()), i_mio_fifo_top.i_occupancy.occ_q);
  endtask

  // ##############################
  // one beat
  // ##############################

  task automatic drive_beat(input string name, input logic wv, input wr_count_t cnt,
                            input logic rr);
    logic  acc_wr;
    logic  acc_rd;
    lane_t popped;
    @(posedge clk_i);
    #1;
    wr_valid = wv;
    wr_count = cnt;
    rd_ready = rr;
    for (int i = 0; i < int'(WR_LANES); i++)
    begin
      wr_data[i] = (i < int'(cnt)) ? next_byte + lane_t'(i) : lane_t'(8'hee);  // ee must be ignored
    end
    #4;
    check_outputs(name);
    acc_rd = rr && (model_q.size() >= int'(RD_LANES));
    acc_wr = wv && ((model_q.size() + int'(WR_LANES)) <= int'(DEPTH));
    if (acc_rd)
    begin
      for (int j = 0; j < int'(RD_LANES); j++)
      begin
        popped = model_q.pop_front();
      end
    end
    if (acc_wr)
    begin
      for (int i = 0; i < int'(cnt); i++)
      begin
        model_q.push_back(next_byte + lane_t'(i));
      end
      next_byte = next_byte + lane_t'(cnt);
    end
  endtask

  initial
  begin
    int          wait_cycles;
    logic [31:0] rnd_bits;
    logic        wv;
    logic        rr;
    wr_count_t   cnt;
    wr_valid = 1'b0;
    wr_count = '0;
    wr_data  = '0;
    rd_ready = 1'b0;
    rst_ni   = 1'b0;
    repeat (2) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    #4;
    check_outputs(grp_name[0]);

    for (int r = 0; r < NUM_ROWS; r++)
    begin
      for (int k = 0; k < int'(rows[r].reps); k++)
      begin
        wv  = rows[r].wv;
        rr  = rows[r].rr;
        cnt = rows[r].cnt;
        if (rows[r].rnd)
        begin
          rnd_bits = $random(seed);
          wv       = rnd_bits[0];
          rr       = rnd_bits[1] | rnd_bits[2];  // pops about three cycles in four
          cnt      = wr_count_t'($unsigned($random(seed)) % 26);
        end
        drive_beat(grp_name[rows[r].grp], wv, cnt, rr);
      end
    end

    // pop until less than one read group is left
    wait_cycles = 0;
    while (model_q.size() >= int'(RD_LANES))
    begin
      if (wait_cycles == TIMEOUT)
      begin
        $display("the final drain did not empty the FIFO within %0d cycles", TIMEOUT);
        abort_run();
      end
      drive_beat(grp_name[7], 1'b0, '0, 1'b1);
      wait_cycles++;
    end
    drive_beat(grp_name[7], 1'b0, '0, 1'b0);

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

/* compile.f */
mio_geom_pkg.sv
mio_types_pkg.sv
mio_occupancy.sv
mio_lane_store.sv
mio_fifo_top.sv
mio_fifo_asserts.sv
tb_mio_fifo.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_mio_fifo
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timing -j 0
SIM_ARGS  ?= +verilator+error+limit+100
FAIL_MSG  ?= Simulation finished: FAIL
PASS_MSG  ?= Simulation finished: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended early, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
